/* common/rv32i_pkg.sv */
package rv32i_pkg;

    // basic data and address word
    typedef logic [31:0] rv32i_word;

    // funct3 field of the LOAD opcode
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // funct3 field of the STORE opcode
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

endpackage

/* common/ooo_pkg.sv */
package ooo_pkg;

    // machine sizes
    localparam int ROB_ENTRIES = 8;
    localparam int TAG_W       = $clog2(ROB_ENTRIES);
    localparam int LSQ_SIZE    = 8;
    localparam int LSQ_PTR_W   = $clog2(LSQ_SIZE);
    localparam int NUM_CDB     = 2;
    localparam int MEM_LATENCY = 2;
    localparam int MEM_CNT_W   = $clog2(MEM_LATENCY + 1);
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_IDX_W  = $clog2(DMEM_WORDS);

    // tag 0 means the value is already present
    typedef logic [TAG_W-1:0]     rob_tag_t;
    typedef logic [LSQ_PTR_W-1:0] lsq_ptr_t;
    typedef logic [LSQ_PTR_W:0]   lsq_cnt_t;
    typedef logic [MEM_CNT_W-1:0] mem_cnt_t;

    // one broadcast slot on the common data bus
    typedef struct packed {
        logic                 valid;
        rob_tag_t             tag;
        rv32i_pkg::rv32i_word value;
    } cdb_entry_t;

    typedef cdb_entry_t [NUM_CDB-1:0] cdb_t;

    // queue entry with the base in qj/vj and the store data in qk/vk
    typedef struct packed {
        logic                 valid;
        logic                 is_store;
        logic [2:0]           funct;
        rob_tag_t             tag;
        rob_tag_t             qj;
        rv32i_pkg::rv32i_word vj;
        rob_tag_t             qk;
        rv32i_pkg::rv32i_word vk;
        rv32i_pkg::rv32i_word imm;
    } lsq_entry_t;

    // what the ROB shows about its oldest instruction
    typedef struct packed {
        logic     is_store;
        rob_tag_t tag;
    } rob_head_t;

endpackage

/* lsq/mem_lane_format.sv */
`timescale 1ns/1ps

module mem_lane_format (
    input  logic [2:0]           funct,
    input  logic [1:0]           addr_low,
    input  rv32i_pkg::rv32i_word store_data,
    input  rv32i_pkg::rv32i_word rdata,
    output logic [3:0]           be,
    output rv32i_pkg::rv32i_word wdata,
    output rv32i_pkg::rv32i_word load_value
);
    import rv32i_pkg::*;

    // bit offset of the addressed byte lane
    logic [4:0] shamt;
    rv32i_word  lane;

    assign shamt = {addr_low, 3'b000};
    assign lane  = rdata >> shamt;

    // store data moved into its lane
    always_comb begin
        wdata = store_data << shamt;
        case (store_funct3_t'(funct))
            sb: be = 4'b0001 << addr_low;
            sh: be = 4'b0011 << addr_low;
            default: begin
                be    = 4'b1111;
                wdata = store_data;
            end
        endcase
    end

    // load lane select and extension
    always_comb begin
        case (load_funct3_t'(funct))
            lb:      load_value = {{24{lane[7]}}, lane[7:0]};
            lh:      load_value = {{16{lane[15]}}, lane[15:0]};
            lbu:     load_value = {24'b0, lane[7:0]};
            lhu:     load_value = {16'b0, lane[15:0]};
            default: load_value = rdata;
        endcase
    end

endmodule

/* lsq/load_store_queue.sv */
`timescale 1ns/1ps

module load_store_queue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  ooo_pkg::cdb_t        cdb,
    input  ooo_pkg::lsq_entry_t  dispatch,
    input  ooo_pkg::rob_head_t   rob_head,
    output ooo_pkg::cdb_entry_t  load_res,
    output logic                 store_done,
    output logic                 full,
    output logic                 almost_full,
    output logic                 mem_read,
    output logic                 mem_write,
    output rv32i_pkg::rv32i_word mem_addr,
    output rv32i_pkg::rv32i_word store_data,
    output logic [2:0]           mem_funct,
    input  logic                 mem_resp,
    input  rv32i_pkg::rv32i_word load_value
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    lsq_entry_t queue [LSQ_SIZE];
    lsq_ptr_t   head_ptr;
    lsq_ptr_t   tail_ptr;
    lsq_cnt_t   count;

    // request in flight for the head entry
    logic outstanding;
    logic req_is_store;
    // response of a request dropped by flush still pending in memory
    logic ignore_resp;

    lsq_entry_t head_entry;
    lsq_entry_t incoming;
    logic       head_ready;
    logic       issue;
    logic       retire;
    logic       accept;
    rv32i_word  issue_addr;

    assign full        = count >= lsq_cnt_t'(LSQ_SIZE - 1);
    assign almost_full = count >= lsq_cnt_t'(LSQ_SIZE - 2);

    assign mem_read  = outstanding && !req_is_store;
    assign mem_write = outstanding && req_is_store;

    assign head_entry = queue[head_ptr];
    assign issue_addr = head_entry.vj + head_entry.imm;

    // stores also wait for the ROB to reach them
    assign head_ready = head_entry.valid && (head_entry.qj == '0) &&
                        (!head_entry.is_store ||
                         ((head_entry.qk == '0) && rob_head.is_store &&
                          (rob_head.tag == head_entry.tag)));

    assign issue  = head_ready && !outstanding && !ignore_resp;
    assign retire = outstanding && mem_resp;
    assign accept = dispatch.valid && (count < lsq_cnt_t'(LSQ_SIZE));

    // catch a broadcast in the same cycle as dispatch
    always_comb begin
        incoming = dispatch;
        for (int j = 0; j < NUM_CDB; j++) begin
            if (cdb[j].valid && (dispatch.qj != '0) && (dispatch.qj == cdb[j].tag)) begin
                incoming.qj = '0;
                incoming.vj = cdb[j].value;
            end
            if (cdb[j].valid && (dispatch.qk != '0) && (dispatch.qk == cdb[j].tag)) begin
                incoming.qk = '0;
                incoming.vk = cdb[j].value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < LSQ_SIZE; i++) begin
                queue[i].valid <= 1'b0;
            end
            head_ptr       <= '0;
            tail_ptr       <= '0;
            count          <= '0;
            outstanding    <= 1'b0;
            load_res.valid <= 1'b0;
            store_done     <= 1'b0;
        end else begin
            load_res.valid <= 1'b0;
            store_done     <= 1'b0;

            // operand wake-up from every bus slot
            for (int i = 0; i < LSQ_SIZE; i++) begin
                for (int j = 0; j < NUM_CDB; j++) begin
                    if (queue[i].valid && cdb[j].valid) begin
                        if ((queue[i].qj != '0) && (queue[i].qj == cdb[j].tag)) begin
                            queue[i].qj <= '0;
                            queue[i].vj <= cdb[j].value;
                        end
                        if ((queue[i].qk != '0) && (queue[i].qk == cdb[j].tag)) begin
                            queue[i].qk <= '0;
                            queue[i].vk <= cdb[j].value;
                        end
                    end
                end
            end

            if (issue) begin
                outstanding  <= 1'b1;
                req_is_store <= head_entry.is_store;
                mem_addr     <= issue_addr;
                store_data   <= head_entry.vk;
                mem_funct    <= head_entry.funct;
            end

            // head leaves on the memory response
            if (retire) begin
                outstanding           <= 1'b0;
                queue[head_ptr].valid <= 1'b0;
                head_ptr              <= head_ptr + 1'b1;
                if (req_is_store) begin
                    store_done <= 1'b1;
                end else begin
                    load_res.valid <= 1'b1;
                    load_res.tag   <= head_entry.tag;
                    load_res.value <= load_value;
                end
            end

            if (accept) begin
                queue[tail_ptr] <= incoming;
                tail_ptr        <= tail_ptr + 1'b1;
            end

            count <= count + lsq_cnt_t'(accept) - lsq_cnt_t'(retire);
        end
    end

    // memory keeps counting after a flush and sends one more pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            ignore_resp <= 1'b0;
        end else if (flush) begin
            ignore_resp <= (outstanding || ignore_resp) && !mem_resp;
        end else if (mem_resp) begin
            ignore_resp <= 1'b0;
        end
    end

endmodule

/* design/data_memory.sv */
`timescale 1ns/1ps

module data_memory (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 read,
    input  logic                 write,
    input  rv32i_pkg::rv32i_word addr,
    input  logic [3:0]           be,
    input  rv32i_pkg::rv32i_word wdata,
    output logic                 resp,
    output rv32i_pkg::rv32i_word rdata
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    rv32i_word             mem [DMEM_WORDS];
    mem_cnt_t              cnt;
    logic [DMEM_IDX_W-1:0] idx;
    logic                  active;
    logic                  last;

    assign idx = addr[DMEM_IDX_W+1:2];

    // a new access starts only when idle and not in the response cycle
    assign active = (cnt != '0) || ((read || write) && !resp);
    assign last   = active && (cnt == mem_cnt_t'(MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            resp <= 1'b0;
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            resp <= 1'b0;
            if (last) begin
                cnt  <= '0;
                resp <= 1'b1;
                // a dropped request leaves memory untouched
                if (write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (be[b]) begin
                            mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                        end
                    end
                end else if (read) begin
                    rdata <= mem[idx];
                end
            end else if (active) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* design/lsq_top.sv */
`timescale 1ns/1ps

module lsq_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  ooo_pkg::cdb_t       cdb,
    input  ooo_pkg::lsq_entry_t dispatch,
    input  ooo_pkg::rob_head_t  rob_head,
    output ooo_pkg::cdb_entry_t load_res,
    output logic                store_done,
    output logic                full,
    output logic                almost_full
);
    import rv32i_pkg::*;

    // queue to memory request
    logic       mem_read;
    logic       mem_write;
    rv32i_word  mem_addr;
    rv32i_word  store_data;
    logic [2:0] mem_funct;

    // formatted data both ways
    logic [3:0] mem_be;
    rv32i_word  mem_wdata;
    rv32i_word  mem_rdata;
    rv32i_word  load_value;
    logic       mem_resp;

    load_store_queue i_lsq (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .cdb         (cdb),
        .dispatch    (dispatch),
        .rob_head    (rob_head),
        .load_res    (load_res),
        .store_done  (store_done),
        .full        (full),
        .almost_full (almost_full),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .store_data  (store_data),
        .mem_funct   (mem_funct),
        .mem_resp    (mem_resp),
        .load_value  (load_value)
    );

    mem_lane_format i_fmt (
        .funct      (mem_funct),
        .addr_low   (mem_addr[1:0]),
        .store_data (store_data),
        .rdata      (mem_rdata),
        .be         (mem_be),
        .wdata      (mem_wdata),
        .load_value (load_value)
    );

    data_memory i_mem (
        .clk   (clk),
        .reset (reset),
        .read  (mem_read),
        .write (mem_write),
        .addr  (mem_addr),
        .be    (mem_be),
        .wdata (mem_wdata),
        .resp  (mem_resp),
        .rdata (mem_rdata)
    );

endmodule

/* verif/tb_lsq.sv */
`timescale 1ns/1ps

module tb_lsq;
    import ooo_pkg::*;
    import rv32i_pkg::*;

    localparam string GOLDEN_FILE = "verif/lsq_golden.txt";
    localparam int    SEED        = 57555;

    logic       clk;
    logic       reset;
    logic       flush;
    cdb_t       cdb;
    lsq_entry_t dispatch;
    rob_head_t  rob_head;
    cdb_entry_t load_res;
    logic       store_done;
    logic       full;
    logic       almost_full;

    // results seen on the output ports in arrival order
    cdb_entry_t load_q [$];
    int         store_count = 0;
    int         cycles = 0;
    int         cycle_limit = 0;

    lsq_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .cdb         (cdb),
        .dispatch    (dispatch),
        .rob_head    (rob_head),
        .load_res    (load_res),
        .store_done  (store_done),
        .full        (full),
        .almost_full (almost_full)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    // pulses are stable around the falling edge
    always @(negedge clk) begin
        if (load_res.valid === 1'b1) begin
            load_q.push_back(load_res);
        end
        if (store_done === 1'b1) begin
            store_count++;
        end
    end

    task automatic check_load(input cdb_entry_t got, input cdb_entry_t exp);
        if (got !== exp) begin
            $display("Fail load_res: got tag %h value %h, expected tag %h value %h",
                     got.tag, got.value, exp.tag, exp.value);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic stop_bad_line(input string cmd);
        $display("golden file line starting with '%s' could not be read", cmd);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic drive_dispatch(input lsq_entry_t entry);
        int gap;
        @(posedge clk);
        dispatch <= entry;
        @(posedge clk);
        dispatch.valid <= 1'b0;
        gap = $urandom % 3;
        repeat (gap) @(posedge clk);
    endtask

    task automatic broadcast(input int slot, input rob_tag_t tag, input rv32i_word value);
        cdb_entry_t e;
        e.valid = 1'b1;
        e.tag   = tag;
        e.value = value;
        @(posedge clk);
        cdb[slot] <= e;
        @(posedge clk);
        cdb[slot].valid <= 1'b0;
    endtask

    task automatic set_rob_head(input logic is_store, input rob_tag_t tag);
        rob_head_t h;
        h.is_store = is_store;
        h.tag      = tag;
        @(posedge clk);
        rob_head <= h;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic expect_load(input rob_tag_t tag, input rv32i_word value);
        cdb_entry_t exp;
        exp.valid = 1'b1;
        exp.tag   = tag;
        exp.value = value;
        while (load_q.size() == 0) @(posedge clk);
        check_load(load_q.pop_front(), exp);
    endtask

    task automatic expect_store();
        while (store_count == 0) @(posedge clk);
        store_count--;
    endtask

    initial begin
        int         fd;
        int         n;
        int         lines;
        int         f [8];
        string      cmd;
        string      line;
        lsq_entry_t entry;

        void'($urandom(SEED));
        clk      = 1'b0;
        reset    = 1'b1;
        flush    = 1'b0;
        cdb      = '0;
        dispatch = '0;
        rob_head = '0;

        // timeout scales with the length of the command file
        lines = 0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", GOLDEN_FILE);
            $display("STATUS: FAIL");
            $fatal(1);
        end
        while ($fgets(line, fd) > 0) begin
            lines++;
        end
        $fclose(fd);
        cycle_limit = 40 * lines;
        fd = $fopen(GOLDEN_FILE, "r");

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        while ($fscanf(fd, " %s", cmd) == 1) begin
            if (cmd == "#") begin
                n = $fgets(line, fd);
            end else if (cmd == "D") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n != 8) stop_bad_line(cmd);
                entry.valid    = 1'b1;
                entry.is_store = f[0];
                entry.funct    = f[1];
                entry.tag      = f[2];
                entry.qj       = f[3];
                entry.vj       = f[4];
                entry.qk       = f[5];
                entry.vk       = f[6];
                entry.imm      = f[7];
                drive_dispatch(entry);
            end else if (cmd == "C") begin
                n = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                if (n != 3) stop_bad_line(cmd);
                broadcast(f[0], f[1], f[2]);
            end else if (cmd == "R") begin
                n = $fscanf(fd, "%h %h", f[0], f[1]);
                if (n != 2) stop_bad_line(cmd);
                set_rob_head(f[0], f[1]);
            end else if (cmd == "I") begin
                n = $fscanf(fd, "%d", f[0]);
                if (n != 1) stop_bad_line(cmd);
                repeat (f[0]) @(posedge clk);
            end else if (cmd == "L") begin
                n = $fscanf(fd, "%h %h", f[0], f[1]);
                if (n != 2) stop_bad_line(cmd);
                expect_load(f[0], f[1]);
            end else if (cmd == "S") begin
                expect_store();
            end else if (cmd == "F") begin
                pulse_flush();
            end else if (cmd == "X") begin
                n = $fscanf(fd, "%h %h", f[0], f[1]);
                if (n != 2) stop_bad_line(cmd);
                @(negedge clk);
                check_flag("full", full, f[0]);
                check_flag("almost_full", almost_full, f[1]);
            end else if (cmd == "N") begin
                // nothing may have come back since the last expected result
                @(posedge clk);
                check_flag("load_res.valid", load_q.size() != 0, 1'b0);
                check_flag("store_done", store_count != 0, 1'b0);
            end else begin
                stop_bad_line(cmd);
            end
        end
        $fclose(fd);

        repeat (10) @(posedge clk);
        if (load_q.size() != 0 || store_count != 0) begin
            $display("results left over at the end: %0d loads, %0d store completions",
                     load_q.size(), store_count);
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* verif/lsq_golden.txt */
# D is_store funct tag qj vj qk vk imm | C slot tag value | R is_store tag | I cycles
# L tag value | S store done | N nothing returned | F flush | X full almost_full
R 1 1
D 1 2 1 0 0 0 11223344 40
S
R 1 2
D 1 0 2 0 40 0 000000AA 1
S
R 1 3
D 1 1 3 0 40 0 0000BEEF 2
S
D 0 2 4 0 40 0 0 0
L 4 BEEFAA44
D 0 0 5 0 40 0 0 1
D 0 4 6 0 40 0 0 1
D 0 1 7 0 40 0 0 2
D 0 5 1 0 40 0 0 2
D 0 0 2 0 3C 0 0 7
L 5 FFFFFFAA
L 6 000000AA
L 7 FFFFBEEF
L 1 0000BEEF
L 2 FFFFFFBE
R 1 4
D 1 0 4 0 40 0 0000007F 3
S
D 0 2 5 6 0 0 0 4
I 3
N
C 1 6 0000003C
L 5 7FEFAA44
R 0 0
D 1 2 6 0 80 7 0 0
D 0 2 1 0 80 0 0 0
C 0 7 CAFEF00D
I 4
N
R 1 6
S
L 1 CAFEF00D
R 0 0
D 1 2 2 0 80 0 12345678 0
D 0 2 3 0 80 0 0 0
D 0 2 4 0 80 0 0 0
D 0 2 5 0 80 0 0 0
D 0 2 7 0 80 0 0 0
D 0 2 1 0 80 0 0 0
X 0 1
D 0 2 3 0 80 0 0 0
X 1 1
F
X 0 0
I 4
N
D 0 2 4 0 80 0 0 0
L 4 CAFEF00D

/* sim.f */
common/rv32i_pkg.sv
common/ooo_pkg.sv
lsq/mem_lane_format.sv
lsq/load_store_queue.sv
design/data_memory.sv
design/lsq_top.sv
verif/tb_lsq.sv
